// File: run.sh
#!/bin/sh
# Builds the wb2axi read bridge testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module wb2axi_read_tb \
    --Mdir obj_dir -o wb2axi_read_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/wb2axi_read_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
    exit 0
fi
exit 1

// File: source/ar_issue.sv
`default_nettype none

module ar_issue (
    input  wire                     ACLK,
    input  wire                     ARESETN,
    read_txn_if.issue               txn,
    output wb2axi_pkg::addr_t       o_araddr,
    output logic                    o_arvalid,
    input  wire                     i_arready
);

    logic issued;
    logic ar_fire;
    logic start;

    // AR transfer happens when both sides are high at the clock edge
    assign ar_fire = o_arvalid & i_arready;

    // New request seen that has not yet gone out on AR
    assign start = txn.req_valid & ~issued;

    // Tells the collect stage that the address phase is over
    assign txn.ar_done = ar_fire;

    // Issued flag keeps a long lived request from being sent twice
    // It is released once capture drops the request after the data beat
    always_ff @(posedge ACLK or negedge ARESETN) begin
        if (!ARESETN) begin
            issued <= 1'b0;
        end else if (!txn.req_valid) begin
            issued <= 1'b0;
        end else if (start) begin
            issued <= 1'b1;
        end
    end

    // Valid rises one cycle after the request and waits out any back-pressure
    always_ff @(posedge ACLK or negedge ARESETN) begin
        if (!ARESETN) begin
            o_arvalid <= 1'b0;
        end else if (start) begin
            o_arvalid <= 1'b1;
        end else if (ar_fire) begin
            o_arvalid <= 1'b0;
        end
    end

    // Address is loaded together with valid and stays put until the handshake
    always_ff @(posedge ACLK) begin
        if (start) begin
            o_araddr <= txn.req_addr;
        end
    end

endmodule

`default_nettype wire

// File: source/r_collect.sv
`default_nettype none

module r_collect (
    input  wire                     ACLK,
    input  wire                     ARESETN,
    read_txn_if.collect             txn,
    input  wire wb2axi_pkg::data_t  i_rdata,
    input  wire                     i_rvalid,
    output logic                    o_rready,
    input  wire                     i_wb_cyc,
    output wb2axi_pkg::data_t       o_wb_rdt,
    output logic                    o_wb_ack
);

    logic r_fire;

    // Single beat read, so the first R transfer completes the transaction
    assign r_fire = i_rvalid & o_rready;

    // Lets capture drop the request in the following cycle
    assign txn.rsp_done = r_fire;

    // Ready opens the cycle after the AR handshake
    // It then stays high through any delay on rvalid
    always_ff @(posedge ACLK or negedge ARESETN) begin
        if (!ARESETN) begin
            o_rready <= 1'b0;
        end else if (txn.ar_done) begin
            o_rready <= 1'b1;
        end else if (r_fire) begin
            o_rready <= 1'b0;
        end
    end

    // Instruction word is held for the core until the next read lands
    always_ff @(posedge ACLK) begin
        if (r_fire) begin
            o_wb_rdt <= i_rdata;
        end
    end

    // Ack rises together with the registered data
    // The core sees it for as long as it keeps cyc high
    // It goes away the cycle after cyc is seen low
    always_ff @(posedge ACLK or negedge ARESETN) begin
        if (!ARESETN) begin
            o_wb_ack <= 1'b0;
        end else if (r_fire) begin
            o_wb_ack <= 1'b1;
        end else if (!i_wb_cyc) begin
            o_wb_ack <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: source/read_txn_if.sv
`default_nettype none

// One read transaction travelling from address capture through AR issue to R collect
interface read_txn_if;
    import wb2axi_pkg::*;

    // Request from the capture stage, held until the cycle after rsp_done
    logic  req_valid;
    // Word aligned address, stable for as long as req_valid is high
    addr_t req_addr;
    // Single cycle pulse in the cycle where the AR handshake takes place
    logic  ar_done;
    // Single cycle pulse in the cycle where the R handshake takes place
    logic  rsp_done;

    // Capture owns the request and releases it once the data has come back
    modport capture (
        output req_valid,
        output req_addr,
        input  rsp_done
    );

    // Issue turns the request into one AR transfer
    modport issue (
        input  req_valid,
        input  req_addr,
        output ar_done
    );

    // Collect waits for the address phase and then takes the data beat
    modport collect (
        input  ar_done,
        output rsp_done
    );

endinterface

`default_nettype wire

// File: source/wb2axi_cfg.svh
`ifndef WB2AXI_CFG_SVH
`define WB2AXI_CFG_SVH

// Width of the fetch address on Wishbone and on the AXI AR channel
`define WB2AXI_ADDR_W 32

// Width of one instruction word on the AXI R channel and on Wishbone
`define WB2AXI_DATA_W 32

// Request cycles after which the serial address is taken as final without a strobe
`define WB2AXI_FALLBACK_CYCLES 33

// Low address bits forced to zero so every read is word aligned
`define WB2AXI_WORD_LSB 2

`endif

// File: source/wb2axi_pkg.sv
`default_nettype none

`include "wb2axi_cfg.svh"

package wb2axi_pkg;

    // Fetch address as driven by the core and as sent on AR
    typedef logic [`WB2AXI_ADDR_W-1:0] addr_t;

    // One instruction word as returned on R and handed back to the core
    typedef logic [`WB2AXI_DATA_W-1:0] data_t;

    // Cycle counter of the address capture stage
    // It must be able to hold the fallback count itself, since it saturates there
    typedef logic [$clog2(`WB2AXI_FALLBACK_CYCLES + 1)-1:0] cap_cnt_t;

endpackage

`default_nettype wire

// File: source/wb2axi_read_top.sv
`default_nettype none

module wb2axi_read_top (
    input  wire                     ACLK,
    input  wire                     ARESETN,

    // Wishbone Classic instruction fetch port of the bit-serial core
    input  wire wb2axi_pkg::addr_t  i_wb_adr,
    input  wire                     i_wb_cyc,
    // Strobe from the core marking the end of the serial address shift
    input  wire                     i_cnt_done,
    output wb2axi_pkg::data_t       o_wb_rdt,
    output logic                    o_wb_ack,

    // AXI4 read address channel
    output wb2axi_pkg::addr_t       o_m_axi_araddr,
    output logic                    o_m_axi_arvalid,
    input  wire                     i_m_axi_arready,

    // AXI4 read data channel
    input  wire wb2axi_pkg::data_t  i_m_axi_rdata,
    input  wire                     i_m_axi_rvalid,
    output logic                    o_m_axi_rready
);

    // Carries the open request between the three stages
    read_txn_if txn ();

    // Works out when the serial address is final and latches it
    wb_addr_capture u_capture (
        .ACLK       (ACLK),
        .ARESETN    (ARESETN),
        .i_wb_adr   (i_wb_adr),
        .i_wb_cyc   (i_wb_cyc),
        .i_cnt_done (i_cnt_done),
        .txn        (txn.capture)
    );

    // Sends the latched address as one AR transfer
    ar_issue u_issue (
        .ACLK      (ACLK),
        .ARESETN   (ARESETN),
        .txn       (txn.issue),
        .o_araddr  (o_m_axi_araddr),
        .o_arvalid (o_m_axi_arvalid),
        .i_arready (i_m_axi_arready)
    );

    // Takes the data beat and answers the core
    r_collect u_collect (
        .ACLK     (ACLK),
        .ARESETN  (ARESETN),
        .txn      (txn.collect),
        .i_rdata  (i_m_axi_rdata),
        .i_rvalid (i_m_axi_rvalid),
        .o_rready (o_m_axi_rready),
        .i_wb_cyc (i_wb_cyc),
        .o_wb_rdt (o_wb_rdt),
        .o_wb_ack (o_wb_ack)
    );

endmodule

`default_nettype wire

// File: source/wb_addr_capture.sv
`default_nettype none

`include "wb2axi_cfg.svh"

module wb_addr_capture (
    input  wire                    ACLK,
    input  wire                    ARESETN,
    input  wire wb2axi_pkg::addr_t i_wb_adr,
    input  wire                    i_wb_cyc,
    input  wire                    i_cnt_done,
    read_txn_if.capture            txn
);
    import wb2axi_pkg::*;

    // Count at which the address is taken as final even without a strobe
    localparam cap_cnt_t cap_limit = cap_cnt_t'(`WB2AXI_FALLBACK_CYCLES);

    logic     cyc_q;
    logic     cyc_rise;
    logic     cnt_done_q;
    cap_cnt_t cap_cnt;
    logic     served;
    logic     strobe_hit;
    logic     count_hit;
    logic     capture;
    addr_t    aligned_adr;

    // The core raises cyc while the address is still being shifted out
    assign cyc_rise = i_wb_cyc & ~cyc_q;

    // Registered copy of the strobe marks the cycle in which the address is final
    // A strobe left over from the previous fetch is dropped on the rising edge of cyc
    always_ff @(posedge ACLK or negedge ARESETN) begin
        if (!ARESETN) begin
            cyc_q      <= 1'b0;
            cnt_done_q <= 1'b0;
        end else begin
            cyc_q <= i_wb_cyc;
            if (cyc_rise) begin
                cnt_done_q <= 1'b0;
            end else begin
                cnt_done_q <= i_cnt_done;
            end
        end
    end

    // Cycle where cyc first goes high sees a count of zero
    // Counting stops once the address has been taken, and at the fallback limit
    always_ff @(posedge ACLK or negedge ARESETN) begin
        if (!ARESETN) begin
            cap_cnt <= '0;
        end else if (!i_wb_cyc) begin
            cap_cnt <= '0;
        end else if (!served && (cap_cnt != cap_limit)) begin
            cap_cnt <= cap_cnt + cap_cnt_t'(1);
        end
    end

    // A nonzero count keeps a stale strobe from cycle 0 out of the decision
    assign strobe_hit = cnt_done_q & (cap_cnt != '0);
    // Fallback for fetches where the strobe never shows up
    assign count_hit  = (cap_cnt == cap_limit);

    // Only one capture per Wishbone cycle and never while a read is still open
    assign capture = i_wb_cyc & ~served & ~txn.req_valid & (strobe_hit | count_hit);

    // Served flag blocks a second capture until the core ends the cycle
    always_ff @(posedge ACLK or negedge ARESETN) begin
        if (!ARESETN) begin
            served <= 1'b0;
        end else if (!i_wb_cyc) begin
            served <= 1'b0;
        end else if (capture) begin
            served <= 1'b1;
        end
    end

    // Word alignment by clearing the byte offset bits
    always_comb begin
        aligned_adr = i_wb_adr;
        aligned_adr[`WB2AXI_WORD_LSB-1:0] = '0;
    end

    // Request rises the cycle after capture and is withdrawn after the data beat
    always_ff @(posedge ACLK or negedge ARESETN) begin
        if (!ARESETN) begin
            txn.req_valid <= 1'b0;
        end else if (capture) begin
            txn.req_valid <= 1'b1;
        end else if (txn.rsp_done) begin
            txn.req_valid <= 1'b0;
        end
    end

    // Address is sampled in the capture cycle itself
    always_ff @(posedge ACLK) begin
        if (capture) begin
            txn.req_addr <= aligned_adr;
        end
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+source
source/wb2axi_pkg.sv
source/read_txn_if.sv
source/wb_addr_capture.sv
source/ar_issue.sv
source/r_collect.sv
source/wb2axi_read_top.sv
test/wb2axi_read_tb.sv

// File: test/wb2axi_read_tb.sv
`default_nettype none

`include "wb2axi_cfg.svh"

module wb2axi_read_tb;
    import wb2axi_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int N_TXN = 24;
    // Upper bound of the random wait before arready and before rvalid
    localparam int MAX_DELAY = 3;
    // Slave adds at most one extra cycle on AR and two on R on top of the random wait
    localparam int SLAVE_DELAY_MAX = 2 * (MAX_DELAY + 2);
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 8
        + N_TXN * (`WB2AXI_FALLBACK_CYCLES + SLAVE_DELAY_MAX + 10);

    logic  ACLK = 1'b0;
    logic  ARESETN = 1'b0;
    addr_t wb_adr = '0;
    logic  wb_cyc = 1'b0;
    logic  cnt_done = 1'b0;
    data_t wb_rdt;
    logic  wb_ack;
    addr_t araddr;
    logic  arvalid;
    logic  arready = 1'b0;
    data_t rdata = '0;
    logic  rvalid = 1'b0;
    logic  rready;

    logic [31:0] rng_state;
    addr_t       exp_araddr = '0;
    logic        fallback_mode = 1'b0;
    int          ar_delay_cfg = 0;
    int          r_delay_cfg = 0;
    int          ar_wait;
    int          r_wait;
    logic        r_armed;
    data_t       r_word = '0;
    int          cyc_age;
    int          ar_count;
    logic        acked;
    logic        ar_fire;
    logic        r_fire;

    assign ar_fire = arvalid & arready;
    assign r_fire  = rvalid & rready;

    always #4 ACLK = ~ACLK;

    wb2axi_read_top dut0 (
        .ACLK            (ACLK),
        .ARESETN         (ARESETN),
        .i_wb_adr        (wb_adr),
        .i_wb_cyc        (wb_cyc),
        .i_cnt_done      (cnt_done),
        .o_wb_rdt        (wb_rdt),
        .o_wb_ack        (wb_ack),
        .o_m_axi_araddr  (araddr),
        .o_m_axi_arvalid (arvalid),
        .i_m_axi_arready (arready),
        .i_m_axi_rdata   (rdata),
        .i_m_axi_rvalid  (rvalid),
        .o_m_axi_rready  (rready)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = lcg_step(rng_state);
        return rng_state;
    endfunction

    // Only the upper LCG bits are used since the low ones repeat with a short period
    function automatic int rand_below(input int n);
        return int'((next_rand() >> 8) % 32'(n));
    endfunction

    // Word the slave returns for a given read address
    function automatic data_t slave_word(input addr_t a);
        return lcg_step(a ^ 32'h9e3779b9);
    endfunction

    function automatic addr_t word_aligned(input addr_t a);
        return a & ~((addr_t'(1) << `WB2AXI_WORD_LSB) - addr_t'(1));
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic flag_mismatch(input string what);
        abort_run($sformatf("Mismatch at time %0t: %s", $time, what));
    endtask

    // One instruction fetch as the serial core performs it
    // The address shifts every cycle until it settles after the strobe, or at cycle 32
    task automatic run_fetch(input logic use_strobe, input logic misalign);
        addr_t final_adr;
        int    strobe_at;
        int    k;
        logic  ack_seen;
        final_adr = next_rand();
        if (misalign) begin
            final_adr = final_adr | addr_t'(3);
        end
        strobe_at = 1 + rand_below(31);
        exp_araddr    <= word_aligned(final_adr);
        fallback_mode <= ~use_strobe;
        ar_delay_cfg  <= rand_below(MAX_DELAY + 1);
        r_delay_cfg   <= rand_below(MAX_DELAY + 1);
        k = 0;
        ack_seen = 1'b0;
        while (!ack_seen) begin
            wb_cyc   <= 1'b1;
            cnt_done <= use_strobe & (k == strobe_at);
            if (use_strobe ? (k > strobe_at) : (k >= 32)) begin
                wb_adr <= final_adr;
            end else begin
                wb_adr <= next_rand();
            end
            @(posedge ACLK);
            ack_seen = wb_ack;
            k = k + 1;
        end
        // The core sometimes keeps the cycle open a little longer
        repeat (rand_below(2)) @(posedge ACLK);
        wb_cyc   <= 1'b0;
        cnt_done <= 1'b0;
        wb_adr   <= next_rand();
        do begin
            @(posedge ACLK);
        end while (wb_ack);
    endtask

    // AXI slave with random arready and rvalid delays, one read at a time
    always @(posedge ACLK) begin
        if (!ARESETN) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            ar_wait <= 0;
            r_wait  <= 0;
            r_armed <= 1'b0;
        end else begin
            if (ar_fire) begin
                arready <= 1'b0;
                ar_wait <= 0;
                r_armed <= 1'b1;
                r_wait  <= r_delay_cfg;
                r_word  <= slave_word(araddr);
            end else if (arvalid && !arready) begin
                if (ar_wait >= ar_delay_cfg) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait + 1;
                end
            end
            if (r_fire) begin
                rvalid <= 1'b0;
            end else if (r_armed) begin
                if (r_wait == 0) begin
                    rvalid  <= 1'b1;
                    rdata   <= r_word;
                    r_armed <= 1'b0;
                end else begin
                    r_wait <= r_wait - 1;
                end
            end
        end
    end

    // Bookkeeping of the Wishbone cycle
    // Cycle 0 is the first cycle with cyc high
    always @(posedge ACLK) begin
        if (!ARESETN) begin
            cyc_age  <= 0;
            ar_count <= 0;
            acked    <= 1'b0;
        end else begin
            if (!wb_cyc) begin
                cyc_age  <= 0;
                ar_count <= 0;
            end else begin
                if (cyc_age < 255) begin
                    cyc_age <= cyc_age + 1;
                end
                if (ar_fire) begin
                    ar_count <= ar_count + 1;
                end
            end
            if (wb_ack) begin
                acked <= 1'b1;
            end else if (wb_cyc && cyc_age == 0) begin
                acked <= 1'b0;
            end
        end
    end

    a_reset_hold: assert property (@(posedge ACLK) !ARESETN && $past(!ARESETN)
        |-> !arvalid && !rready && !wb_ack)
        else flag_mismatch("outputs not idle during reset");
    a_reset_exit: assert property (@(posedge ACLK) $rose(ARESETN)
        |-> !arvalid && !rready && !wb_ack)
        else flag_mismatch("outputs not idle right after reset");
    a_ar_addr: assert property (@(posedge ACLK) disable iff (!ARESETN)
        ar_fire |-> araddr == exp_araddr)
        else flag_mismatch($sformatf("araddr %h, expected %h", araddr, exp_araddr));
    a_fallback_wait: assert property (@(posedge ACLK) disable iff (!ARESETN)
        $rose(arvalid) && fallback_mode |-> cyc_age >= `WB2AXI_FALLBACK_CYCLES + 2)
        else flag_mismatch($sformatf("arvalid rose in cycle %0d without strobe", cyc_age));
    a_ar_hold: assert property (@(posedge ACLK) disable iff (!ARESETN)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else flag_mismatch("AR request changed under back-pressure");
    a_r_hold: assert property (@(posedge ACLK) disable iff (!ARESETN)
        rready && !rvalid |=> rready)
        else flag_mismatch("rready dropped before rvalid");
    a_rdata: assert property (@(posedge ACLK) disable iff (!ARESETN)
        $rose(wb_ack) |-> wb_rdt == r_word)
        else flag_mismatch($sformatf("wb_rdt %h, expected %h", wb_rdt, r_word));
    a_ack_hold: assert property (@(posedge ACLK) disable iff (!ARESETN)
        wb_ack && wb_cyc |=> wb_ack)
        else flag_mismatch("ack dropped while cyc high");
    a_ack_clear: assert property (@(posedge ACLK) disable iff (!ARESETN)
        wb_ack && !wb_cyc |=> !wb_ack)
        else flag_mismatch("ack still high after cyc went low");
    a_one_ar: assert property (@(posedge ACLK) disable iff (!ARESETN)
        ar_fire |-> ar_count == 0 && wb_cyc)
        else flag_mismatch("second AR handshake in one Wishbone cycle");
    a_ar_per_cycle: assert property (@(posedge ACLK) disable iff (!ARESETN)
        $fell(wb_cyc) |-> ar_count == 1)
        else flag_mismatch($sformatf("%0d AR handshakes in one Wishbone cycle", ar_count));
    a_quiet_after_ack: assert property (@(posedge ACLK) disable iff (!ARESETN)
        acked |-> !arvalid)
        else flag_mismatch("arvalid high between ack and the next cycle");

    initial begin : stimulus
        rng_state = 32'hba7c83be;
        repeat (RESET_CYCLES) @(posedge ACLK);
        ARESETN <= 1'b1;
        @(posedge ACLK);
        for (int i = 0; i < N_TXN; i++) begin
            // Every fourth fetch leaves out the strobe and relies on the fallback count
            run_fetch((i % 4) != 3, (i % 3) == 0);
        end
        repeat (4) @(posedge ACLK);
        $display("Testbench passed");
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge ACLK);
        abort_run("Timeout, the fetch sequence did not complete in time");
    end

endmodule

`default_nettype wire
